/* vlog.f */
design/com_pkg.sv
design/com_cfg_pkg.sv
design/com_crc_if.sv
design/crc_engine.sv
design/frame_check.sv
design/com_rx.sv
design/com_rx_top.sv
verif/com_rx_props.sv
verif/com_rx_tb.sv

/* Bender.yml */
package:
  name: com_rx

sources:
  - design/com_pkg.sv
  - design/com_cfg_pkg.sv
  - design/com_crc_if.sv
  - design/crc_engine.sv
  - design/frame_check.sv
  - design/com_rx.sv
  - design/com_rx_top.sv
  - target: simulation
    files:
      - verif/com_rx_props.sv
      - verif/com_rx_tb.sv

/* verif/com_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module com_rx_tb
    import com_pkg::*, com_cfg_pkg::*;
;

    logic             clk = 1'b0;
    logic             rst;
    logic [7:0]       com_rxd;
    logic             fd;
    logic [len_w-1:0] ram_txa_init;
    logic             fs;
    btype_t           btype;
    logic [7:0]       bdata;
    logic [3:0]       device_idx;
    logic [3:0]       data_idx;
    logic [3:0]       device_stat;
    logic [len_w-1:0] ram_txa;
    logic [7:0]       ram_txd;
    logic             ram_txen;
    logic [len_w-1:0] data_len;
    logic             crc_ok;

    logic [15:0]      lfsr = 16'd14;
    logic [7:0]       frame[$];
    logic [7:0]       exp_payload[$];
    logic [len_w-1:0] ram_base;
    btype_t           last_btype = bt_init;
    btype_t           exp_btype;
    logic [7:0]       exp_bdata;
    logic [3:0]       exp_dev;
    logic [3:0]       exp_didx;
    logic [3:0]       exp_dstat;
    logic [len_w-1:0] exp_len;
    logic             exp_ok;
    logic [3:0]       heads[3] = '{head_dlink, head_dtype, head_dtemp};
    int               wr_idx = 0;
    int               fs_rises = 0;
    int               errors = 0;
    int               mark = 0;
    int               passed = 0;
    int               failed = 0;

    com_rx_top u_com_rx_top (
        .clk          (clk),
        .rst          (rst),
        .com_rxd      (com_rxd),
        .fd           (fd),
        .ram_txa_init (ram_txa_init),
        .fs           (fs),
        .btype        (btype),
        .bdata        (bdata),
        .device_idx   (device_idx),
        .data_idx     (data_idx),
        .device_stat  (device_stat),
        .ram_txa      (ram_txa),
        .ram_txd      (ram_txd),
        .ram_txen     (ram_txen),
        .data_len     (data_len),
        .crc_ok       (crc_ok)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // galois lfsr, taps 16, 14, 13, 11.
    function logic next_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_bit()};
        end
        return v;
    endfunction

    function logic [7:0] junk_byte();
        logic [7:0] b;
        b = 8'(rand_bits(8));
        if (b == pid_sync) begin
            b = b ^ 8'h01;
        end
        return b;
    endfunction

    // one byte, msb first, register of width w.
    function logic [15:0] crc_update(input logic [15:0] cur, input logic [7:0] b,
                                     input int w, input logic [15:0] poly);
        logic [15:0] r;
        logic        top;
        r = cur;
        for (int i = 7; i >= 0; i--) begin
            top = r[w-1];
            r = (r << 1) & 16'((32'h1 << w) - 1);
            if (top ^ b[i]) begin
                r = r ^ poly;
            end
        end
        return r;
    endfunction

    function void model_frame();
        int          n;
        logic [15:0] c;
        exp_bdata = '0;
        exp_dev   = '0;
        exp_didx  = '0;
        exp_dstat = '0;
        exp_len   = '0;
        exp_ok    = 1'b1;
        exp_payload.delete();
        case (frame[1])
            pid_ack:   last_btype = bt_ack;
            pid_nak:   last_btype = bt_nak;
            pid_stall: last_btype = bt_stall;
            pid_stat: begin
                n = {frame[2][3:0], frame[3]};
                case (frame[4][7:4])
                    head_dlink: last_btype = bt_dlink;
                    head_dtype: last_btype = bt_dtype;
                    head_dtemp: last_btype = bt_dtemp;
                    default:    last_btype = last_btype;
                endcase
                exp_dev   = frame[4][3:0];
                exp_bdata = frame[5];
                c = 16'(crc5_seed);
                for (int i = 0; i < n; i++) begin
                    c = crc_update(c, frame[4 + i], 5, 16'(crc5_poly));
                end
                exp_ok = (c[4:0] == frame[4 + n][4:0]);
            end
            pid_data0, pid_data1: begin
                n = {frame[2][3:0], frame[3]};
                last_btype = (frame[1] == pid_data0) ? bt_data0 : bt_data1;
                exp_dev   = frame[4][3:0];
                exp_bdata = frame[5];
                exp_didx  = frame[5][7:4];
                exp_dstat = frame[5][3:0];
                exp_len   = len_w'(n - 2);
                c = crc16_seed;
                for (int i = 0; i < n; i++) begin
                    c = crc_update(c, frame[4 + i], 16, crc16_poly);
                    if (i >= 2) begin
                        exp_payload.push_back(frame[4 + i]);
                    end
                end
                exp_ok = (c == {frame[4 + n], frame[5 + n]});
            end
            default: last_btype = last_btype;
        endcase
        exp_btype = last_btype;
    endfunction

    function void report_mismatch(input string what, input int got, input int want);
        $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, want);
        errors++;
    endfunction

    task build_short(input logic [7:0] id);
        frame.delete();
        frame.push_back(pid_sync);
        frame.push_back(id);
    endtask

    task build_status(input logic [3:0] head, input bit bad);
        int          n;
        logic [15:0] c;
        logic [7:0]  b;
        n = 2 + rand_bits(2);
        c = 16'(crc5_seed);
        build_short(pid_stat);
        frame.push_back(8'(n >> 8));
        frame.push_back(8'(n));
        for (int i = 0; i < n; i++) begin
            b = (i == 0) ? {head, 4'(rand_bits(4))} : 8'(rand_bits(8));
            frame.push_back(b);
            c = crc_update(c, b, 5, 16'(crc5_poly));
        end
        if (bad) begin
            c = c ^ (16'h1 << (rand_bits(3) % 5));
        end
        frame.push_back({3'b000, c[4:0]});
    endtask

    // kind 1 corrupts a payload byte, kind 2 a crc byte.
    task build_data(input logic [7:0] id, input int kind);
        int          n;
        logic [15:0] c;
        logic [7:0]  b;
        n = 4 + (rand_bits(5) % 19);
        c = crc16_seed;
        build_short(id);
        frame.push_back(8'(n >> 8));
        frame.push_back(8'(n));
        for (int i = 0; i < n; i++) begin
            b = 8'(rand_bits(8));
            frame.push_back(b);
            c = crc_update(c, b, 16, crc16_poly);
        end
        if (kind == 1) begin
            frame[6 + (rand_bits(5) % (n - 2))] ^= 8'h01 << rand_bits(3);
        end
        frame.push_back(c[15:8]);
        frame.push_back(c[7:0]);
        if (kind == 2) begin
            frame[frame.size() - 1 - rand_bits(1)] ^= 8'h01 << rand_bits(3);
        end
    endtask

    task run_frame();
        int lead;
        int hold;
        int t;
        ram_base = len_w'(rand_bits(len_w));
        ram_txa_init = ram_base;
        model_frame();
        wr_idx = 0;
        lead = rand_bits(2);
        for (int i = 0; i < lead; i++) begin
            com_rxd = junk_byte();
            @(negedge clk);
        end
        foreach (frame[i]) begin
            com_rxd = frame[i];
            @(negedge clk);
        end
        t = 0;
        while (!fs && t < 10) begin
            com_rxd = junk_byte();
            @(negedge clk);
            t++;
        end
        if (!fs) begin
            $display("Timeout at %0t: fs did not rise after the frame", $time);
            errors++;
        end else begin
            assert (t == 0) else report_mismatch("fs rise delay", t, 0);
        end
        // line bytes during fs, sync included, must be dropped.
        hold = rand_bits(3);
        for (int h = 0; h < hold; h++) begin
            com_rxd = 8'(rand_bits(8));
            @(negedge clk);
            assert (fs) else report_mismatch("fs", fs, 1);
        end
        fd = 1'b1;
        com_rxd = 8'(rand_bits(8));
        @(negedge clk);
        fd = 1'b0;
        t = 0;
        while (fs && t < 4) begin
            @(negedge clk);
            t++;
        end
        if (fs) begin
            $display("Timeout at %0t: fs stayed high after fd", $time);
            errors++;
        end else begin
            assert (t == 0) else report_mismatch("fs release delay", t, 0);
        end
    endtask

    task check_frame();
        assert (btype == exp_btype) else report_mismatch("btype", btype, exp_btype);
        assert (bdata == exp_bdata) else report_mismatch("bdata", bdata, exp_bdata);
        assert (device_idx == exp_dev) else report_mismatch("device_idx", device_idx, exp_dev);
        assert (data_idx == exp_didx) else report_mismatch("data_idx", data_idx, exp_didx);
        assert (device_stat == exp_dstat)
            else report_mismatch("device_stat", device_stat, exp_dstat);
        assert (data_len == exp_len) else report_mismatch("data_len", data_len, exp_len);
        assert (crc_ok == exp_ok) else report_mismatch("crc_ok", crc_ok, exp_ok);
        assert (wr_idx == exp_payload.size())
            else report_mismatch("ram write count", wr_idx, exp_payload.size());
    endtask

    initial begin : compare_outputs
        logic fs_q;
        fs_q = 1'b0;
        forever begin
            @(negedge clk);
            if (fs && !fs_q) begin
                fs_rises++;
                check_frame();
            end
            fs_q = fs;
        end
    end

    // ram writes against the expected payload list.
    always @(negedge clk) begin
        if (ram_txen) begin
            assert (wr_idx < exp_payload.size()) else begin
                $display("Extra RAM write at %0t to address %0h", $time, ram_txa);
                errors++;
            end
            if (wr_idx < exp_payload.size()) begin
                assert (ram_txa == len_w'(ram_base + wr_idx))
                    else report_mismatch("ram_txa", ram_txa, len_w'(ram_base + wr_idx));
                assert (ram_txd == exp_payload[wr_idx])
                    else report_mismatch("ram_txd", ram_txd, exp_payload[wr_idx]);
            end
            wr_idx++;
        end
    end

    task finish_test(input string name);
        if (errors == mark) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        int rises;
        int k;
        rst = 1'b1;
        com_rxd = 8'h00;
        fd = 1'b0;
        ram_txa_init = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        assert (!fs) else report_mismatch("fs", fs, 0);
        assert (!ram_txen) else report_mismatch("ram_txen", ram_txen, 0);
        assert (btype == bt_init) else report_mismatch("btype", btype, bt_init);
        assert (bdata == 0 && device_idx == 0 && data_idx == 0 && device_stat == 0 &&
                data_len == 0) else report_mismatch("header fields", bdata, 0);
        rises = fs_rises;
        for (int i = 0; i < 16; i++) begin
            com_rxd = junk_byte();
            @(negedge clk);
        end
        assert (fs_rises == rises) else report_mismatch("fs rises", fs_rises, rises);
        finish_test("reset and idle line");

        build_short(pid_ack);
        run_frame();
        build_short(pid_nak);
        run_frame();
        build_short(pid_stall);
        run_frame();
        // unknown ids right after frames that carry a crc.
        build_status(head_dtemp, 1'b0);
        run_frame();
        build_short(pid_cmd);
        run_frame();
        build_data(pid_data1, 0);
        run_frame();
        build_short(8'h3C);
        run_frame();
        finish_test("handshake and unknown ids");

        for (int r = 0; r < 6; r++) begin
            build_status(heads[r % 3], r >= 3);
            run_frame();
        end
        finish_test("status packets");

        for (int i = 0; i < 8; i++) begin
            build_data((i % 2) ? pid_data1 : pid_data0, 0);
            run_frame();
        end
        finish_test("data packets");

        for (int i = 0; i < 9; i++) begin
            build_data(rand_bits(1) ? pid_data1 : pid_data0, i % 3);
            run_frame();
        end
        finish_test("data crc corruption");

        for (int i = 0; i < 12; i++) begin
            k = rand_bits(3) % 5;
            case (k)
                0: build_short(pid_ack);
                1: build_short(pid_cmd);
                2: build_status(heads[rand_bits(2) % 3], rand_bits(1));
                default: build_data(rand_bits(1) ? pid_data1 : pid_data0, rand_bits(2) % 3);
            endcase
            run_frame();
        end
        finish_test("back-to-back mixed frames");

        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/com_rx_props.sv */
`timescale 1ns/1ps
`default_nettype none

module com_rx_props
    import com_cfg_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             fs,
    input logic             fd,
    input logic             ram_txen,
    input logic [len_w-1:0] ram_txa
);

    // payload writes are over before the frame is reported.
    a_no_write_in_done: assert property (@(posedge clk) disable iff (rst)
        !(fs && ram_txen))
        else $error("fs and ram_txen high in the same cycle");

    a_fs_holds: assert property (@(posedge clk) disable iff (rst)
        fs && !fd |=> fs)
        else $error("fs dropped while fd was low");

    // one address per payload byte.
    a_addr_step: assert property (@(posedge clk) disable iff (rst)
        ram_txen ##1 ram_txen |-> ram_txa == len_w'($past(ram_txa) + 1))
        else $error("ram_txa did not step by one between writes");

endmodule

bind com_rx com_rx_props u_com_rx_props (
    .clk      (clk),
    .rst      (rst),
    .fs       (fs),
    .fd       (fd),
    .ram_txen (ram_txen),
    .ram_txa  (ram_txa)
);

`default_nettype wire

/* design/com_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module com_rx_top
    import com_pkg::*, com_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [7:0]       com_rxd,
    input  logic             fd,
    input  logic [len_w-1:0] ram_txa_init,
    output logic             fs,
    output btype_t           btype,
    output logic [7:0]       bdata,
    output logic [3:0]       device_idx,
    output logic [3:0]       data_idx,
    output logic [3:0]       device_stat,
    output logic [len_w-1:0] ram_txa,
    output logic [7:0]       ram_txd,
    output logic             ram_txen,
    output logic [len_w-1:0] data_len,
    output logic             crc_ok
);

    com_crc_if crc_bus ();

    crc5_t  crc5_value;
    crc16_t crc16_value;

    com_rx u_com_rx (
        .clk          (clk),
        .rst          (rst),
        .com_rxd      (com_rxd),
        .fd           (fd),
        .ram_txa_init (ram_txa_init),
        .fs           (fs),
        .btype        (btype),
        .bdata        (bdata),
        .device_idx   (device_idx),
        .data_idx     (data_idx),
        .device_stat  (device_stat),
        .ram_txa      (ram_txa),
        .ram_txd      (ram_txd),
        .ram_txen     (ram_txen),
        .data_len     (data_len),
        .crc          (crc_bus)
    );

    // status packets.
    crc_engine #(
        .crc_t (crc5_t),
        .poly  (crc5_poly),
        .seed  (crc5_seed)
    ) u_crc5 (
        .clk   (clk),
        .rst   (rst),
        .crc   (crc_bus),
        .value (crc5_value)
    );

    // data packets.
    crc_engine #(
        .crc_t (crc16_t),
        .poly  (crc16_poly),
        .seed  (crc16_seed)
    ) u_crc16 (
        .clk   (clk),
        .rst   (rst),
        .crc   (crc_bus),
        .value (crc16_value)
    );

    frame_check u_frame_check (
        .clk    (clk),
        .rst    (rst),
        .crc    (crc_bus),
        .btype  (btype),
        .crc5   (crc5_value),
        .crc16  (crc16_value),
        .crc_ok (crc_ok)
    );

endmodule

`default_nettype wire

/* design/com_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module com_rx
    import com_pkg::*, com_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [7:0]       com_rxd,
    input  logic             fd,
    input  logic [len_w-1:0] ram_txa_init,
    output logic             fs,
    output btype_t           btype,
    output logic [7:0]       bdata,
    output logic [3:0]       device_idx,
    output logic [3:0]       data_idx,
    output logic [3:0]       device_stat,
    output logic [len_w-1:0] ram_txa,
    output logic [7:0]       ram_txd,
    output logic             ram_txen,
    output logic [len_w-1:0] data_len,
    com_crc_if.parser        crc
);

    typedef enum logic [3:0] {
        st_wait,
        st_pid,
        st_slen_hi,
        st_slen_lo,
        st_stat,
        st_crc5,
        st_dlen_hi,
        st_dlen_lo,
        st_head0,
        st_head1,
        st_data,
        st_crc_hi,
        st_crc_lo,
        st_done
    } state_t;

    state_t           state;
    state_t           next_state;
    logic [len_w-1:0] len_q;
    logic [len_w-1:0] len_full;
    logic [len_w-1:0] num;

    // length as seen on the low length byte.
    assign len_full = {len_q[len_w-1:8], com_rxd};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_wait;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_wait: begin
                if (com_rxd == pid_sync) begin
                    next_state = st_pid;
                end
            end
            st_pid: begin
                case (com_rxd)
                    pid_ack, pid_nak, pid_stall: next_state = st_done;
                    pid_stat:                    next_state = st_slen_hi;
                    pid_data0, pid_data1:        next_state = st_dlen_hi;
                    default:                     next_state = st_done;
                endcase
            end
            st_slen_hi: next_state = st_slen_lo;
            st_slen_lo: begin
                if (len_full == '0) begin
                    next_state = st_crc5;
                end else begin
                    next_state = st_stat;
                end
            end
            st_stat: begin
                if (num == len_q - len_w'(1)) begin
                    next_state = st_crc5;
                end
            end
            st_crc5:    next_state = st_done;
            st_dlen_hi: next_state = st_dlen_lo;
            st_dlen_lo: next_state = st_head0;
            st_head0:   next_state = st_head1;
            st_head1: begin
                // header bytes count towards the length.
                if (len_q <= len_w'(2)) begin
                    next_state = st_crc_hi;
                end else begin
                    next_state = st_data;
                end
            end
            st_data: begin
                if (num == data_len - len_w'(1)) begin
                    next_state = st_crc_hi;
                end
            end
            st_crc_hi: next_state = st_crc_lo;
            st_crc_lo: next_state = st_done;
            st_done: begin
                if (fd) begin
                    next_state = st_wait;
                end
            end
            default: next_state = st_wait;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            len_q <= '0;
        end else if (state == st_slen_hi || state == st_dlen_hi) begin
            len_q[len_w-1:8] <= com_rxd[len_w-9:0];
        end else if (state == st_slen_lo || state == st_dlen_lo) begin
            len_q <= len_full;
        end
    end

    // body byte index.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= '0;
        end else if (state == st_stat || state == st_data) begin
            num <= num + 1'b1;
        end else begin
            num <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btype <= bt_init;
        end else if (state == st_pid) begin
            case (com_rxd)
                pid_ack:   btype <= bt_ack;
                pid_nak:   btype <= bt_nak;
                pid_stall: btype <= bt_stall;
                pid_data0: btype <= bt_data0;
                pid_data1: btype <= bt_data1;
                default:   btype <= btype;
            endcase
        end else if (state == st_stat && num == '0) begin
            case (com_rxd[7:4])
                head_dlink: btype <= bt_dlink;
                head_dtype: btype <= bt_dtype;
                head_dtemp: btype <= bt_dtemp;
                default:    btype <= btype;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bdata       <= '0;
            device_idx  <= '0;
            data_idx    <= '0;
            device_stat <= '0;
            data_len    <= '0;
        end else if (state == st_wait) begin
            bdata       <= '0;
            device_idx  <= '0;
            data_idx    <= '0;
            device_stat <= '0;
            data_len    <= '0;
        end else if (state == st_stat) begin
            if (num == len_w'(0)) begin
                device_idx <= com_rxd[3:0];
            end
            if (num == len_w'(1)) begin
                bdata <= com_rxd;
            end
        end else if (state == st_head0) begin
            device_idx <= com_rxd[3:0];
        end else if (state == st_head1) begin
            bdata       <= com_rxd;
            data_idx    <= com_rxd[7:4];
            device_stat <= com_rxd[3:0];
            data_len    <= len_q - len_w'(2);
        end
    end

    // ram write port, one cycle behind the line.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_txen <= 1'b0;
            ram_txa  <= '0;
        end else begin
            ram_txen <= (state == st_data);
            if (state == st_data) begin
                ram_txa <= ram_txa_init + num;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data) begin
            ram_txd <= com_rxd;
        end
    end

    assign fs = (state == st_done);

    assign crc.clr        = (state == st_wait) && (com_rxd == pid_sync);
    assign crc.en         = (state == st_stat) || (state == st_head0) ||
                            (state == st_head1) || (state == st_data);
    assign crc.din        = com_rxd;
    assign crc.crc_hi_stb = (state == st_crc_hi);
    assign crc.crc_lo_stb = (state == st_crc5) || (state == st_crc_lo);

endmodule

`default_nettype wire

/* design/frame_check.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_check
    import com_pkg::*, com_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    com_crc_if.check crc,
    input  btype_t   btype,
    input  crc5_t    crc5,
    input  crc16_t   crc16,
    output logic     crc_ok
);

    logic [7:0] rx_hi;
    logic [7:0] rx_lo;
    logic       rx_seen;
    logic       match;

    always_ff @(posedge clk) begin
        if (crc.crc_hi_stb) begin
            rx_hi <= crc.din;
        end
        if (crc.crc_lo_stb) begin
            rx_lo <= crc.din;
        end
    end

    // set once the frame has delivered its last crc byte.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_seen <= 1'b0;
        end else if (crc.clr) begin
            rx_seen <= 1'b0;
        end else if (crc.crc_lo_stb) begin
            rx_seen <= 1'b1;
        end
    end

    always_comb begin
        case (btype)
            bt_dlink, bt_dtype, bt_dtemp: match = (crc5 == rx_lo[$bits(crc5_t)-1:0]);
            bt_data0, bt_data1:           match = (crc16 == {rx_hi, rx_lo});
            default:                      match = 1'b1;
        endcase
    end

    // frames without a crc field always pass.
    assign crc_ok = !rx_seen || match;

endmodule

`default_nettype wire

/* design/crc_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module crc_engine
    import com_cfg_pkg::*;
#(
    parameter type  crc_t = crc16_t,
    parameter crc_t poly  = crc16_poly,
    parameter crc_t seed  = crc16_seed
) (
    input  logic      clk,
    input  logic      rst,
    com_crc_if.engine crc,
    output crc_t      value
);

    localparam int crc_w = $bits(crc_t);

    // eight serial steps, msb of the byte first.
    function automatic crc_t crc_step(input crc_t cur, input logic [7:0] data);
        crc_t acc;
        acc = cur;
        for (int i = 7; i >= 0; i--) begin
            if (data[i] ^ acc[crc_w-1]) begin
                acc = crc_t'(acc << 1) ^ poly;
            end else begin
                acc = crc_t'(acc << 1);
            end
        end
        return acc;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            value <= seed;
        end else if (crc.clr) begin
            value <= seed;
        end else if (crc.en) begin
            value <= crc_step(value, crc.din);
        end
    end

endmodule

`default_nettype wire

/* design/com_crc_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface com_crc_if;

    logic       clr;
    logic       en;
    logic [7:0] din;
    logic       crc_hi_stb;
    logic       crc_lo_stb;

    modport parser (
        output clr,
        output en,
        output din,
        output crc_hi_stb,
        output crc_lo_stb
    );

    modport engine (
        input clr,
        input en,
        input din
    );

    // clr marks the start of a frame for the checker too.
    modport check (
        input clr,
        input din,
        input crc_hi_stb,
        input crc_lo_stb
    );

endinterface

`default_nettype wire

/* design/com_cfg_pkg.sv */
`default_nettype none

package com_cfg_pkg;

    // lengths and ram addresses.
    localparam int len_w = 12;

    typedef logic [4:0]  crc5_t;
    typedef logic [15:0] crc16_t;

    // msb first, no reflection, no final xor.
    localparam crc5_t  crc5_poly  = 5'h05;
    localparam crc5_t  crc5_seed  = 5'h1F;
    localparam crc16_t crc16_poly = 16'h8005;
    localparam crc16_t crc16_seed = 16'hFFFF;

endpackage

`default_nettype wire

/* design/com_pkg.sv */
`default_nettype none

package com_pkg;

    // packet id bytes as they appear on the link.
    localparam logic [7:0] pid_sync  = 8'h0F;
    localparam logic [7:0] pid_ack   = 8'h2D;
    localparam logic [7:0] pid_nak   = 8'hA5;
    localparam logic [7:0] pid_stall = 8'hE1;
    localparam logic [7:0] pid_cmd   = 8'h1E;
    localparam logic [7:0] pid_stat  = 8'hD2;
    localparam logic [7:0] pid_data0 = 8'h96;
    localparam logic [7:0] pid_data1 = 8'h5A;

    // decoded packet type.
    typedef enum logic [3:0] {
        bt_init  = 4'b0000,
        bt_ack   = 4'b0001,
        bt_nak   = 4'b0010,
        bt_stall = 4'b0011,
        bt_dlink = 4'b1000,
        bt_dtype = 4'b1001,
        bt_dtemp = 4'b1010,
        bt_data0 = 4'b1101,
        bt_data1 = 4'b1110
    } btype_t;

    // high nibble of status byte 0.
    localparam logic [3:0] head_dlink = 4'hD;
    localparam logic [3:0] head_dtype = 4'h1;
    localparam logic [3:0] head_dtemp = 4'h9;

endpackage

`default_nettype wire
